//--- common/sb_pkg.sv
// scoreboard package: widths, functional-unit codes and the entry and port structs
package sb_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;
  // tag width, caps the queue at 8 entries
  localparam int unsigned TRANS_ID_W = 3;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;

  // functional unit that produces the result
  typedef enum logic [2:0] {
    FU_NONE   = 3'd0,
    FU_ALU    = 3'd1,
    FU_LOAD   = 3'd2,
    FU_STORE  = 3'd3,
    FU_MULT   = 3'd4,
    FU_BRANCH = 3'd5,
    FU_CSR    = 3'd6
  } fu_t;

  // --------------------
  // structs
  // --------------------
  // decoded instruction as seen by the scoreboard
  typedef struct packed {
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     pc;
    trans_id_t trans_id;
  } sb_instr_t;

  // one slot of the entry queue
  typedef struct packed {
    logic      issued;
    logic      valid;
    logic      ex_valid;
    xlen_t     result;
    sb_instr_t instr;
  } sb_entry_t;

  // one writeback port from a functional unit
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    xlen_t     data;
    logic      ex_valid;
  } wb_port_t;

endpackage

//--- scoreboard/sb_queue_ctrl.sv
// scoreboard queue control: issue handshake, issue and commit pointers, occupancy count
`timescale 1ns/1ps

module sb_queue_ctrl #(
  parameter int unsigned NR_ENTRIES = 8
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              unresolved_branch_i,
  input  sb_pkg::sb_instr_t decoded_instr_i,
  input  logic              decoded_valid_i,
  output logic              decoded_ack_o,
  output sb_pkg::sb_instr_t issue_instr_o,
  output logic              issue_valid_o,
  input  logic              issue_ack_i,
  input  logic              commit_ack_i,
  output logic              sb_full_o,
  output logic              alloc_en_o,
  output sb_pkg::trans_id_t issue_ptr_o,
  output sb_pkg::trans_id_t commit_ptr_o
);
  import sb_pkg::*;

  localparam int unsigned PTR_W    = $clog2(NR_ENTRIES);
  // pointers wrap at the queue depth, which is a power of two
  localparam trans_id_t   PTR_MASK = trans_id_t'(NR_ENTRIES - 1);

  trans_id_t      issue_ptr_q, issue_ptr_n;
  trans_id_t      commit_ptr_q, commit_ptr_n;
  // one bit wider than the pointer, top bit means full
  logic [PTR_W:0] cnt_q, cnt_n;
  logic           full;

  assign full      = cnt_q[PTR_W];
  assign sb_full_o = full;

  // --------------------
  // issue handshake
  // --------------------
  always_comb begin
    issue_instr_o          = decoded_instr_i;
    // tag with the slot it will occupy
    issue_instr_o.trans_id = issue_ptr_q;
    issue_valid_o          = decoded_valid_i & ~full & ~unresolved_branch_i;
    decoded_ack_o          = issue_ack_i & ~full;
  end

  // no allocation while the queue is being flushed
  assign alloc_en_o = decoded_valid_i & decoded_ack_o & ~flush_i;

  // --------------------
  // pointers and count
  // --------------------
  always_comb begin
    issue_ptr_n  = issue_ptr_q;
    commit_ptr_n = commit_ptr_q;
    cnt_n        = cnt_q + {{PTR_W{1'b0}}, alloc_en_o} - {{PTR_W{1'b0}}, commit_ack_i};
    if (alloc_en_o) begin
      issue_ptr_n = (issue_ptr_q + trans_id_t'(1)) & PTR_MASK;
    end
    if (commit_ack_i) begin
      commit_ptr_n = (commit_ptr_q + trans_id_t'(1)) & PTR_MASK;
    end
    // flush empties the queue in one cycle
    if (flush_i) begin
      issue_ptr_n  = '0;
      commit_ptr_n = '0;
      cnt_n        = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issue_ptr_q  <= issue_ptr_n;
      commit_ptr_q <= commit_ptr_n;
      cnt_q        <= cnt_n;
    end
  end

  assign issue_ptr_o  = issue_ptr_q;
  assign commit_ptr_o = commit_ptr_q;

endmodule

//--- scoreboard/sb_entry_mem.sv
// scoreboard entry memory: allocation, writeback, fu-none completion, commit release and flush
`timescale 1ns/1ps

module sb_entry_mem #(
  parameter int unsigned NR_ENTRIES  = 8,
  parameter int unsigned NR_WB_PORTS = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  logic                                  alloc_en_i,
  input  sb_pkg::trans_id_t                     issue_ptr_i,
  input  sb_pkg::trans_id_t                     commit_ptr_i,
  input  sb_pkg::sb_instr_t                     instr_i,
  input  sb_pkg::wb_port_t [NR_WB_PORTS-1:0]    wb_i,
  input  logic                                  commit_ack_i,
  output sb_pkg::sb_entry_t [NR_ENTRIES-1:0]    entries_o,
  output sb_pkg::sb_entry_t                     commit_o
);
  import sb_pkg::*;

  // status flags per slot
  logic [NR_ENTRIES-1:0] issued_q, issued_n;
  logic [NR_ENTRIES-1:0] valid_q, valid_n;
  logic [NR_ENTRIES-1:0] ex_valid_q, ex_valid_n;
  // payload per slot
  sb_instr_t             instr_q [NR_ENTRIES];
  xlen_t                 result_q [NR_ENTRIES];

  // --------------------
  // flag next state
  // --------------------
  always_comb begin
    issued_n   = issued_q;
    valid_n    = valid_q;
    ex_valid_n = ex_valid_q;

    // new slot starts issued but not finished
    if (alloc_en_i) begin
      issued_n[issue_ptr_i]   = 1'b1;
      valid_n[issue_ptr_i]    = 1'b0;
      ex_valid_n[issue_ptr_i] = 1'b0;
    end

    // no functional unit, so the entry finishes by itself
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (issued_q[i] && (instr_q[i].fu == FU_NONE)) begin
        valid_n[i] = 1'b1;
      end
    end

    // writebacks only land on issued slots
    // stale results after a flush are dropped here
    for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
      if (wb_i[p].valid && issued_q[wb_i[p].trans_id]) begin
        valid_n[wb_i[p].trans_id]    = 1'b1;
        ex_valid_n[wb_i[p].trans_id] = wb_i[p].ex_valid;
      end
    end

    // commit releases the oldest slot
    if (commit_ack_i) begin
      issued_n[commit_ptr_i] = 1'b0;
      valid_n[commit_ptr_i]  = 1'b0;
    end

    if (flush_i) begin
      issued_n   = '0;
      valid_n    = '0;
      ex_valid_n = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q   <= '0;
      valid_q    <= '0;
      ex_valid_q <= '0;
    end else begin
      issued_q   <= issued_n;
      valid_q    <= valid_n;
      ex_valid_q <= ex_valid_n;
    end
  end

  // --------------------
  // payload writes
  // --------------------
  always_ff @(posedge clk_i) begin
    if (alloc_en_i) begin
      instr_q[issue_ptr_i] <= instr_i;
    end
    for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
      if (wb_i[p].valid && issued_q[wb_i[p].trans_id]) begin
        result_q[wb_i[p].trans_id] <= wb_i[p].data;
      end
    end
  end

  // assemble the entry view for the consumers
  always_comb begin
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      entries_o[i].issued   = issued_q[i];
      entries_o[i].valid    = valid_q[i];
      entries_o[i].ex_valid = ex_valid_q[i];
      entries_o[i].result   = result_q[i];
      entries_o[i].instr    = instr_q[i];
    end
  end

  // head of the queue, tag rebuilt from the pointer
  always_comb begin
    commit_o                = entries_o[commit_ptr_i];
    commit_o.instr.trans_id = commit_ptr_i;
  end

endmodule

//--- scoreboard/sb_clobber.sv
// scoreboard clobber table: functional unit that will write each general register
`timescale 1ns/1ps

module sb_clobber #(
  parameter int unsigned NR_ENTRIES = 8
) (
  input  sb_pkg::sb_entry_t [NR_ENTRIES-1:0]    entries_i,
  output sb_pkg::fu_t [sb_pkg::NUM_REGS-1:0]    rd_clobber_o
);
  import sb_pkg::*;

  // --------------------
  // table build
  // --------------------
  always_comb begin
    // default is free
    for (int unsigned r = 0; r < NUM_REGS; r++) begin
      rd_clobber_o[r] = FU_NONE;
    end

    // walk from the top slot down
    // so the lowest index is written last and wins
    for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
      if (entries_i[i].issued) begin
        rd_clobber_o[entries_i[i].instr.rd] = entries_i[i].instr.fu;
      end
    end

    // x0 is hardwired, never clobbered
    rd_clobber_o[0] = FU_NONE;
  end

endmodule

//--- scoreboard/sb_operand_fwd.sv
// scoreboard operand forwarding: two read ports fed from writeback ports and finished entries
`timescale 1ns/1ps

module sb_operand_fwd #(
  parameter int unsigned NR_ENTRIES  = 8,
  parameter int unsigned NR_WB_PORTS = 2
) (
  input  sb_pkg::sb_entry_t [NR_ENTRIES-1:0]    entries_i,
  input  sb_pkg::wb_port_t [NR_WB_PORTS-1:0]    wb_i,
  input  sb_pkg::reg_addr_t                     rs1_i,
  input  sb_pkg::reg_addr_t                     rs2_i,
  output sb_pkg::xlen_t                         rs1_o,
  output logic                                  rs1_valid_o,
  output sb_pkg::xlen_t                         rs2_o,
  output logic                                  rs2_valid_o
);
  import sb_pkg::*;

  // lookup result, valid on top of the data
  logic [XLEN:0] rs1_hit;
  logic [XLEN:0] rs2_hit;

  // --------------------
  // one read port
  // --------------------
  function automatic logic [XLEN:0] lookup(input reg_addr_t rs);
    logic  found;
    xlen_t data;
    found = 1'b0;
    data  = '0;

    // writeback ports first, lower port wins
    // a port carrying an exception has no usable data
    for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
      if (!found && wb_i[p].valid && !wb_i[p].ex_valid &&
          (entries_i[wb_i[p].trans_id].instr.rd == rs)) begin
        found = 1'b1;
        data  = wb_i[p].data;
      end
    end

    // then finished entries, lower index wins
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (!found && entries_i[i].issued && entries_i[i].valid &&
          (entries_i[i].instr.rd == rs)) begin
        found = 1'b1;
        data  = entries_i[i].result;
      end
    end

    // x0 reads come from the register file
    if (rs == '0) begin
      found = 1'b0;
      data  = '0;
    end
    return {found, data};
  endfunction

  // --------------------
  // port outputs
  // --------------------
  always_comb begin
    rs1_hit = lookup(rs1_i);
    rs2_hit = lookup(rs2_i);
  end

  assign rs1_valid_o = rs1_hit[XLEN];
  assign rs1_o       = rs1_hit[XLEN-1:0];
  assign rs2_valid_o = rs2_hit[XLEN];
  assign rs2_o       = rs2_hit[XLEN-1:0];

endmodule

//--- scoreboard/scoreboard_top.sv
// scoreboard top level: queue control, entry memory, clobber table and operand forwarding
`timescale 1ns/1ps

module scoreboard_top #(
  parameter int unsigned NR_ENTRIES  = 8,
  parameter int unsigned NR_WB_PORTS = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        flush_i,
  input  logic                                        unresolved_branch_i,
  // decode side
  input  sb_pkg::sb_instr_t                           decoded_instr_i,
  input  logic                                        decoded_valid_i,
  output logic                                        decoded_ack_o,
  // issue side
  output sb_pkg::sb_instr_t                           issue_instr_o,
  output logic                                        issue_valid_o,
  input  logic                                        issue_ack_i,
  // writeback ports
  input  sb_pkg::wb_port_t [NR_WB_PORTS-1:0]          wb_i,
  // commit port
  output sb_pkg::sb_entry_t                           commit_o,
  input  logic                                        commit_ack_i,
  // operand read ports
  input  sb_pkg::reg_addr_t                           rs1_i,
  input  sb_pkg::reg_addr_t                           rs2_i,
  output sb_pkg::xlen_t                               rs1_o,
  output sb_pkg::xlen_t                               rs2_o,
  output logic                                        rs1_valid_o,
  output logic                                        rs2_valid_o,
  // clobber table towards issue
  output sb_pkg::fu_t [sb_pkg::NUM_REGS-1:0]          rd_clobber_o,
  output logic                                        sb_full_o
);
  import sb_pkg::*;

  // internal wiring
  logic                        alloc_en;
  trans_id_t                   issue_ptr;
  trans_id_t                   commit_ptr;
  sb_entry_t [NR_ENTRIES-1:0]  entries;

  // --------------------
  // producer side
  // --------------------
  sb_queue_ctrl #(
    .NR_ENTRIES (NR_ENTRIES)
  ) u_queue_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .unresolved_branch_i (unresolved_branch_i),
    .decoded_instr_i     (decoded_instr_i),
    .decoded_valid_i     (decoded_valid_i),
    .decoded_ack_o       (decoded_ack_o),
    .issue_instr_o       (issue_instr_o),
    .issue_valid_o       (issue_valid_o),
    .issue_ack_i         (issue_ack_i),
    .commit_ack_i        (commit_ack_i),
    .sb_full_o           (sb_full_o),
    .alloc_en_o          (alloc_en),
    .issue_ptr_o         (issue_ptr),
    .commit_ptr_o        (commit_ptr)
  );

  // entry storage, fed with the tagged instruction
  sb_entry_mem #(
    .NR_ENTRIES  (NR_ENTRIES),
    .NR_WB_PORTS (NR_WB_PORTS)
  ) u_entry_mem (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .alloc_en_i   (alloc_en),
    .issue_ptr_i  (issue_ptr),
    .commit_ptr_i (commit_ptr),
    .instr_i      (issue_instr_o),
    .wb_i         (wb_i),
    .commit_ack_i (commit_ack_i),
    .entries_o    (entries),
    .commit_o     (commit_o)
  );

  // --------------------
  // consumer side
  // --------------------
  sb_clobber #(
    .NR_ENTRIES (NR_ENTRIES)
  ) u_clobber (
    .entries_i    (entries),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd #(
    .NR_ENTRIES  (NR_ENTRIES),
    .NR_WB_PORTS (NR_WB_PORTS)
  ) u_operand_fwd (
    .entries_i   (entries),
    .wb_i        (wb_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .rs1_o       (rs1_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_o       (rs2_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

//--- test/tb_clk_gen.sv
// testbench clock and reset generator: free-running clock, reset held low after start
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 10,
  parameter int unsigned RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  // free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- test/sb_sva.sv
// scoreboard assertions on the issue and commit handshakes and the x0 clobber entry
`timescale 1ns/1ps

module sb_sva (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        issue_ack_i,
  input  logic        issue_valid_i,
  input  logic        commit_ack_i,
  input  logic        commit_valid_i,
  input  sb_pkg::fu_t clobber_x0_i
);
  import sb_pkg::*;

  // count of failed assertions polled by the testbench
  int unsigned fail_cnt = 0;

  // --------------------
  // handshakes
  // --------------------
  // issue stage only acks an offered instruction
  a_issue_ack: assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_ack_i |-> issue_valid_i
  ) else begin
    $error("issue_ack_i high while issue_valid_o is low");
    fail_cnt++;
  end

  // commit only acks a finished head entry
  a_commit_ack: assert property (
    @(posedge clk_i) disable iff (!rst_ni) commit_ack_i |-> commit_valid_i
  ) else begin
    $error("commit_ack_i high while commit_o.valid is low");
    fail_cnt++;
  end

  // --------------------
  // clobber table
  // --------------------
  a_x0_free: assert property (
    @(posedge clk_i) disable iff (!rst_ni) clobber_x0_i == FU_NONE
  ) else begin
    $error("rd_clobber_o[0] is not FU_NONE");
    fail_cnt++;
  end

endmodule

//--- test/tb_scoreboard.sv
// scoreboard testbench driving a table of issue, writeback, read, commit and flush steps
`timescale 1ns/1ps

module tb_scoreboard;
  import sb_pkg::*;

  localparam int unsigned NR_WB      = 2;
  // cycles a commit may wait for its head entry
  localparam int unsigned WAIT_LIMIT = 50;

  typedef enum int {
    OP_ISSUE, OP_WB, OP_READ, OP_COMMIT, OP_FLUSH, OP_IDLE, OP_FREE
  } op_e;

  // one step of the table
  // unused fields stay zero
  typedef struct {
    op_e                  op;
    logic [2:0]           fu;      // issue and commit fu or clobber fu for idle
    reg_addr_t            rd;      // issue rd or clobber register for idle
    xlen_t                pc;
    xlen_t                result;
    trans_id_t            tid;
    logic                 ok;      // accepted or commit_o.valid for idle
    logic                 full;
    logic                 branch;
    logic                 ex;
    wb_port_t [NR_WB-1:0] wb;
    reg_addr_t            rs1;
    reg_addr_t            rs2;
    xlen_t                exp1;
    xlen_t                exp2;
    logic                 ev1;
    logic                 ev2;
  } row_t;

  localparam wb_port_t NO_WB = '0;

  logic                      clk;
  logic                      rst_n;
  logic                      flush;
  logic                      unresolved_branch;
  sb_instr_t                 decoded_instr;
  logic                      decoded_valid;
  logic                      decoded_ack;
  sb_instr_t                 issue_instr;
  logic                      issue_valid;
  logic                      issue_ack;
  wb_port_t [NR_WB-1:0]      wb;
  sb_entry_t                 commit;
  logic                      commit_ack;
  reg_addr_t                 rs1;
  reg_addr_t                 rs2;
  xlen_t                     rs1_data;
  xlen_t                     rs2_data;
  logic                      rs1_valid;
  logic                      rs2_valid;
  fu_t [NUM_REGS-1:0]        rd_clobber;
  logic                      sb_full;
  row_t                      steps[$];

  tb_clk_gen #(
    .PERIOD_NS  (10),
    .RST_CYCLES (16)
  ) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  scoreboard_top u_dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .flush_i             (flush),
    .unresolved_branch_i (unresolved_branch),
    .decoded_instr_i     (decoded_instr),
    .decoded_valid_i     (decoded_valid),
    .decoded_ack_o       (decoded_ack),
    .issue_instr_o       (issue_instr),
    .issue_valid_o       (issue_valid),
    .issue_ack_i         (issue_ack),
    .wb_i                (wb),
    .commit_o            (commit),
    .commit_ack_i        (commit_ack),
    .rs1_i               (rs1),
    .rs2_i               (rs2),
    .rs1_o               (rs1_data),
    .rs2_o               (rs2_data),
    .rs1_valid_o         (rs1_valid),
    .rs2_valid_o         (rs2_valid),
    .rd_clobber_o        (rd_clobber),
    .sb_full_o           (sb_full)
  );

  bind scoreboard_top sb_sva u_sva (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_ack_i    (issue_ack_i),
    .issue_valid_i  (issue_valid_o),
    .commit_ack_i   (commit_ack_i),
    .commit_valid_i (commit_o.valid),
    .clobber_x0_i   (rd_clobber_o[0])
  );

  // --------------------
  // checking
  // --------------------
  task automatic end_with_failure();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      end_with_failure();
    end
  endtask

  // stop as soon as a bound assertion has fired
  task automatic poll_assertions(int unsigned step);
    if (u_dut.u_sva.fail_cnt != 0) begin
      $display("a scoreboard assertion failed before step %0d", step);
      end_with_failure();
    end
  endtask

  // --------------------
  // table rows
  // --------------------
  function automatic wb_port_t make_wb(logic v, trans_id_t tid, xlen_t data, logic ex);
    wb_port_t p;
    p.valid    = v;
    p.trans_id = tid;
    p.data     = data;
    p.ex_valid = ex;
    return p;
  endfunction

  function automatic row_t plain_row(op_e op);
    row_t r;
    r = '{op: op, default: '0};
    return r;
  endfunction

  function automatic row_t issue_row(logic [2:0] fu, reg_addr_t rd, xlen_t pc, trans_id_t tid,
                                     logic ok, logic full, logic branch);
    row_t r;
    r        = plain_row(OP_ISSUE);
    r.fu     = fu;
    r.rd     = rd;
    r.pc     = pc;
    r.tid    = tid;
    r.ok     = ok;
    r.full   = full;
    r.branch = branch;
    return r;
  endfunction

  // writeback on both ports plus read expectations for a read row
  function automatic row_t read_row(op_e op, wb_port_t p0, wb_port_t p1,
                                    reg_addr_t rs1_a, xlen_t exp1, logic ev1,
                                    reg_addr_t rs2_a, xlen_t exp2, logic ev2);
    row_t r;
    r       = plain_row(op);
    r.wb[0] = p0;
    r.wb[1] = p1;
    r.rs1   = rs1_a;
    r.exp1  = exp1;
    r.ev1   = ev1;
    r.rs2   = rs2_a;
    r.exp2  = exp2;
    r.ev2   = ev2;
    return r;
  endfunction

  function automatic row_t commit_row(trans_id_t tid, logic [2:0] fu, xlen_t pc,
                                      xlen_t result, logic ex);
    row_t r;
    r        = plain_row(OP_COMMIT);
    r.tid    = tid;
    r.fu     = fu;
    r.pc     = pc;
    r.result = result;
    r.ex     = ex;
    return r;
  endfunction

  function automatic row_t idle_row(reg_addr_t rd, logic [2:0] fu, logic full, logic cvalid);
    row_t r;
    r      = plain_row(OP_IDLE);
    r.rd   = rd;
    r.fu   = fu;
    r.full = full;
    r.ok   = cvalid;
    return r;
  endfunction

  task automatic build_table();
    steps.push_back(plain_row(OP_FREE));
    // tags in order with two instructions on x5 and one on x0
    steps.push_back(issue_row(FU_ALU, 5'd5, 32'h0000_1000, 3'd0, 1'b1, 1'b0, 1'b0));
    steps.push_back(issue_row(FU_LOAD, 5'd6, 32'h0000_1004, 3'd1, 1'b1, 1'b0, 1'b0));
    steps.push_back(issue_row(FU_MULT, 5'd5, 32'h0000_1008, 3'd2, 1'b1, 1'b0, 1'b0));
    steps.push_back(issue_row(FU_NONE, 5'd7, 32'h0000_100c, 3'd3, 1'b1, 1'b0, 1'b0));
    // stalled by an unresolved branch
    steps.push_back(issue_row(FU_ALU, 5'd8, 32'h0000_10f0, 3'd0, 1'b0, 1'b0, 1'b1));
    steps.push_back(issue_row(FU_STORE, 5'd0, 32'h0000_1010, 3'd4, 1'b1, 1'b0, 1'b0));
    steps.push_back(idle_row(5'd5, FU_ALU, 1'b0, 1'b0));
    steps.push_back(idle_row(5'd6, FU_LOAD, 1'b0, 1'b0));
    steps.push_back(idle_row(5'd0, FU_NONE, 1'b0, 1'b0));
    // out of order writeback then forwarding
    steps.push_back(read_row(OP_WB, make_wb(1'b1, 3'd2, 32'h2222_0000, 1'b0), NO_WB,
                             5'd0, '0, 1'b0, 5'd0, '0, 1'b0));
    steps.push_back(read_row(OP_READ, NO_WB, NO_WB,
                             5'd5, 32'h2222_0000, 1'b1, 5'd6, '0, 1'b0));
    steps.push_back(read_row(OP_READ, make_wb(1'b1, 3'd1, 32'haaaa_0001, 1'b0),
                             make_wb(1'b1, 3'd0, 32'hbbbb_0000, 1'b0),
                             5'd5, 32'hbbbb_0000, 1'b1, 5'd6, 32'haaaa_0001, 1'b1));
    steps.push_back(issue_row(FU_ALU, 5'd9, 32'h0000_1014, 3'd5, 1'b1, 1'b0, 1'b0));
    steps.push_back(issue_row(FU_LOAD, 5'd9, 32'h0000_1018, 3'd6, 1'b1, 1'b0, 1'b0));
    // port 0 wins over port 1
    steps.push_back(read_row(OP_READ, make_wb(1'b1, 3'd6, 32'h6666_0000, 1'b0),
                             make_wb(1'b1, 3'd5, 32'h5555_0000, 1'b0),
                             5'd9, 32'h6666_0000, 1'b1, 5'd0, '0, 1'b0));
    // port with an exception is skipped and the finished entry used
    steps.push_back(read_row(OP_READ, make_wb(1'b1, 3'd5, 32'heeee_0005, 1'b1),
                             make_wb(1'b1, 3'd4, 32'h4444_0000, 1'b0),
                             5'd9, 32'h5555_0000, 1'b1, 5'd5, 32'hbbbb_0000, 1'b1));
    // x0 stays invalid with a finished entry and a live port on it
    steps.push_back(read_row(OP_READ, make_wb(1'b1, 3'd4, 32'h4444_0000, 1'b0), NO_WB,
                             5'd0, '0, 1'b0, 5'd0, '0, 1'b0));
    steps.push_back(issue_row(FU_CSR, 5'd10, 32'h0000_101c, 3'd7, 1'b1, 1'b0, 1'b0));
    steps.push_back(issue_row(FU_ALU, 5'd11, 32'h0000_1020, 3'd0, 1'b0, 1'b1, 1'b0));
    // commit in allocation order
    steps.push_back(commit_row(3'd0, FU_ALU, 32'h0000_1000, 32'hbbbb_0000, 1'b0));
    steps.push_back(idle_row(5'd5, FU_MULT, 1'b0, 1'b1));
    steps.push_back(commit_row(3'd1, FU_LOAD, 32'h0000_1004, 32'haaaa_0001, 1'b0));
    steps.push_back(commit_row(3'd2, FU_MULT, 32'h0000_1008, 32'h2222_0000, 1'b0));
    steps.push_back(idle_row(5'd5, FU_NONE, 1'b0, 1'b1));
    steps.push_back(commit_row(3'd3, FU_NONE, 32'h0000_100c, '0, 1'b0));
    steps.push_back(commit_row(3'd4, FU_STORE, 32'h0000_1010, 32'h4444_0000, 1'b0));
    steps.push_back(commit_row(3'd5, FU_ALU, 32'h0000_1014, 32'heeee_0005, 1'b1));
    // flush and stale writebacks before the restart at tag 0
    steps.push_back(plain_row(OP_FLUSH));
    steps.push_back(plain_row(OP_FREE));
    steps.push_back(read_row(OP_WB, make_wb(1'b1, 3'd0, 32'h7777_0000, 1'b0),
                             make_wb(1'b1, 3'd7, 32'h7777_0007, 1'b0),
                             5'd0, '0, 1'b0, 5'd0, '0, 1'b0));
    steps.push_back(idle_row(5'd10, FU_NONE, 1'b0, 1'b0));
    steps.push_back(issue_row(FU_ALU, 5'd12, 32'h0000_3000, 3'd0, 1'b1, 1'b0, 1'b0));
    steps.push_back(idle_row(5'd12, FU_ALU, 1'b0, 1'b0));
    steps.push_back(read_row(OP_WB, make_wb(1'b1, 3'd0, 32'h3030_0000, 1'b0), NO_WB,
                             5'd0, '0, 1'b0, 5'd0, '0, 1'b0));
    steps.push_back(commit_row(3'd0, FU_ALU, 32'h0000_3000, 32'h3030_0000, 1'b0));
    steps.push_back(plain_row(OP_FREE));
  endtask

  // --------------------
  // stimulus
  // --------------------
  task automatic drive_defaults();
    flush             = 1'b0;
    unresolved_branch = 1'b0;
    decoded_valid     = 1'b0;
    decoded_instr     = '0;
    issue_ack         = 1'b0;
    wb                = '0;
    commit_ack        = 1'b0;
    rs1               = '0;
    rs2               = '0;
  endtask

  // called on a falling edge and checks a little later in the same cycle
  task automatic apply_step(row_t r);
    int unsigned waited;
    drive_defaults();
    case (r.op)
      OP_ISSUE: begin
        decoded_valid          = 1'b1;
        decoded_instr.fu       = fu_t'(r.fu);
        decoded_instr.rd       = r.rd;
        decoded_instr.pc       = r.pc;
        // decode tag is ignored by the scoreboard
        decoded_instr.trans_id = '1;
        unresolved_branch      = r.branch;
        issue_ack              = r.ok;
        #1;
        check_value("issue_valid_o", issue_valid, r.ok);
        check_value("decoded_ack_o", decoded_ack, r.ok);
        check_value("sb_full_o", sb_full, r.full);
        if (r.ok) begin
          check_value("issue_instr_o.trans_id", issue_instr.trans_id, r.tid);
          check_value("issue_instr_o.fu", issue_instr.fu, r.fu);
          check_value("issue_instr_o.rd", issue_instr.rd, r.rd);
          check_value("issue_instr_o.pc", issue_instr.pc, r.pc);
        end
      end
      OP_WB: begin
        wb = r.wb;
      end
      OP_READ: begin
        wb  = r.wb;
        rs1 = r.rs1;
        rs2 = r.rs2;
        #1;
        check_value("rs1_valid_o", rs1_valid, r.ev1);
        check_value("rs1_o", rs1_data, r.exp1);
        check_value("rs2_valid_o", rs2_valid, r.ev2);
        check_value("rs2_o", rs2_data, r.exp2);
      end
      OP_COMMIT: begin
        waited = 0;
        while (commit.valid !== 1'b1) begin
          if (waited >= WAIT_LIMIT) begin
            $display("commit_o.valid stayed low for %0d cycles, tag %0d", waited, r.tid);
            end_with_failure();
          end
          waited++;
          @(negedge clk);
        end
        check_value("commit_o.trans_id", commit.instr.trans_id, r.tid);
        check_value("commit_o.fu", commit.instr.fu, r.fu);
        check_value("commit_o.pc", commit.instr.pc, r.pc);
        check_value("commit_o.ex_valid", commit.ex_valid, r.ex);
        // fu none entries carry no result
        if (r.fu != FU_NONE) begin
          check_value("commit_o.result", commit.result, r.result);
        end
        commit_ack = 1'b1;
      end
      OP_FLUSH: begin
        flush = 1'b1;
      end
      OP_IDLE: begin
        #1;
        check_value("sb_full_o", sb_full, r.full);
        check_value("commit_o.valid", commit.valid, r.ok);
        check_value($sformatf("rd_clobber_o[%0d]", r.rd), rd_clobber[r.rd], r.fu);
      end
      OP_FREE: begin
        rs1 = 5'd1;
        rs2 = 5'd2;
        #1;
        check_value("sb_full_o", sb_full, 1'b0);
        check_value("commit_o.valid", commit.valid, 1'b0);
        check_value("rs1_valid_o", rs1_valid, 1'b0);
        check_value("rs2_valid_o", rs2_valid, 1'b0);
        for (int i = 0; i < NUM_REGS; i++) begin
          check_value($sformatf("rd_clobber_o[%0d]", i), rd_clobber[i], FU_NONE);
        end
      end
      default: begin
      end
    endcase
  endtask

  initial begin
    int unsigned waited;
    drive_defaults();
    build_table();
    waited = 0;
    while (rst_n !== 1'b1) begin
      if (waited >= 100) begin
        $display("reset was not released within %0d cycles", waited);
        end_with_failure();
      end
      waited++;
      @(negedge clk);
    end
    foreach (steps[i]) begin
      @(negedge clk);
      poll_assertions(i);
      apply_step(steps[i]);
    end
    @(negedge clk);
    drive_defaults();
    @(negedge clk);
    if (u_dut.u_sva.fail_cnt == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures were reported", u_dut.u_sva.fail_cnt);
      end_with_failure();
    end
  end

endmodule

//--- verilog.f
common/sb_pkg.sv
scoreboard/sb_queue_ctrl.sv
scoreboard/sb_entry_mem.sv
scoreboard/sb_clobber.sv
scoreboard/sb_operand_fwd.sv
scoreboard/scoreboard_top.sv
test/tb_clk_gen.sv
test/sb_sva.sv
test/tb_scoreboard.sv
